// ==== bench/FetchTb.sv ====
// Run from the project root so bench/fetch_stimulus.txt resolves; fills return in request order
`timescale 1ns/1ps
`default_nettype none

module FetchTb;

    logic               clk;
    logic               rstN;
    FetchPkg::redirectT extRedirect;
    logic               decodeStall;
    FetchPkg::fillT     fill;
    logic               missReq;
    logic [31:0]        missAddr;
    FetchPkg::fetchOutT fetchOut;

    logic [31:0] mem [256];                     // Memory image by word index
    logic [15:0] lfsr = 16'd29456;
    int          redirAt[$];
    logic [31:0] redirTgt[$];
    int          stallAt[$];
    int          stallLen[$];
    int          testAt[$];
    int          testNum[$];
    logic [31:0] pendAddr[$];                   // Outstanding miss lines
    int          pendDue[$];                    // Cycle each fill is due
    int          lineReqs [64] = '{default: 0};
    int          cycle = 0;
    int          accepted = 0;
    int          expTotal = 0;
    int          errors = 0;
    int          testNo = 1;
    int          testErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    FetchTop UUT (
        .clk         (clk),
        .rstN        (rstN),
        .extRedirect (extRedirect),
        .decodeStall (decodeStall),
        .fill        (fill),
        .missReq     (missReq),
        .missAddr    (missAddr),
        .fetchOut    (fetchOut)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;                     // 20 ns period
        end
    end

    // ************************************************************
    // Helpers
    // ************************************************************
    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic drawDelay(output int d);
        d = 1;
        for (int i = 0; i < 3; i++) begin
            d    = d + (int'(lfsr[0]) << i);    // One step per bit
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic compareValue(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
            testErrors++;
        end
    endtask

    task automatic reportFailure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        testErrors++;
    endtask

    task automatic closeTest();
        $display("Test %0d finished with %0d errors", testNo, testErrors);
        testsRun++;
        errors += testErrors;
        if (testErrors != 0) begin
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic readStimulus();
        int          fd;
        int          n;
        string       text;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = 32'h6A00_0000 ^ (32'(i) << 2);   // Unlisted words
        end
        fd = $fopen("bench/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            reportFailure("Stimulus file bench/fetch_stimulus.txt could not be opened");
            return;
        end
        while ($fgets(text, fd) != 0) begin
            n = $sscanf(text, "%c", kind);
            case (kind)
                "M": begin
                    n = $sscanf(text, "%c %h %h", kind, a, b);
                    mem[a[9:2]] = b;
                end
                "R": begin
                    n = $sscanf(text, "%c %d %h", kind, a, b);
                    redirAt.push_back(int'(a));
                    redirTgt.push_back(b);
                end
                "S": begin
                    n = $sscanf(text, "%c %d %d", kind, a, b);
                    stallAt.push_back(int'(a));
                    stallLen.push_back(int'(b));
                end
                "T": begin
                    n = $sscanf(text, "%c %d %d", kind, a, b);
                    testAt.push_back(int'(a));
                    testNum.push_back(int'(b));
                end
                "E": begin
                    n = $sscanf(text, "%c %d", kind, a);
                    expTotal = int'(a);
                end
                default: n = 3;                 // Comment line
            endcase
            if (n < 2) begin
                reportFailure($sformatf("Malformed stimulus line: %s", text));
            end
        end
        $fclose(fd);
        if (expTotal == 0) begin
            reportFailure("Stimulus file gives no expected output count");
        end
    endtask

    // ************************************************************
    // Main sequence
    // ************************************************************
    initial begin
        int                 delay;
        int                 lastDue = 0;
        int                 stallLeft = 0;
        int                 limit;
        logic               dup;
        logic               stallNow;
        logic               redirNow;
        logic               stallPrev = 1'b0;
        logic               flushPrev = 1'b0;
        logic               fillSeen = 1'b0;
        logic               expFault;
        logic [31:0]        expPc = FetchPkg::ResetPc;
        logic [31:0]        expInsn;
        logic [7:0]         base;
        FetchPkg::fetchOutT prevOut;

        rstN        = 1'b0;
        extRedirect = '0;
        decodeStall = 1'b0;
        fill        = '0;
        readStimulus();
        limit = 40 * expTotal + 200;            // Cycle budget

        repeat (8) begin
            @(posedge clk);
            #1;
            if (fetchOut.valid !== 1'b0 || missReq !== 1'b0) begin
                reportFailure("Output valid or miss request not low during reset");
            end
        end
        #1;
        rstN = 1'b1;

        while (accepted < expTotal && cycle < limit) begin
            @(posedge clk);
            #1;                                 // Sample settled outputs
            cycle++;

            // Memory model takes the request
            if (missReq) begin
                dup = 1'b0;
                foreach (pendAddr[i]) begin
                    if (pendAddr[i] == missAddr) begin
                        dup = 1'b1;
                    end
                end
                if (missAddr[3:0] != 4'h0 || missAddr >= FetchPkg::MemBytes) begin
                    reportFailure($sformatf("Miss request for bad address %h", missAddr));
                end else if (dup) begin
                    reportFailure($sformatf("Line %h requested again while outstanding",
                                            missAddr));
                end else begin
                    if (testNo <= 3 && lineReqs[missAddr[9:4]] != 0) begin
                        reportFailure($sformatf("Line %h requested twice", missAddr));
                    end
                    lineReqs[missAddr[9:4]]++;
                    drawDelay(delay);
                    lastDue = (cycle + delay > lastDue) ? cycle + delay : lastDue + 1;
                    pendAddr.push_back(missAddr);
                    pendDue.push_back(lastDue);
                end
            end

            if (flushPrev && fetchOut.valid) begin
                reportFailure("Output still valid in the cycle after a flush");
            end else if (stallPrev && !flushPrev && fetchOut !== prevOut) begin
                reportFailure("Output changed while decode was stalled");
            end
            if (!fillSeen && fetchOut.valid) begin
                reportFailure("Output valid before the first fill");
            end

            #1;                                 // Drive 2 ns after the edge
            while (testAt.size() > 0 && accepted >= testAt[0]) begin
                closeTest();
                testNo = testNum[0];
                testAt.delete(0);
                testNum.delete(0);
            end

            // Fill strobe of at most one line per cycle
            fill = '0;
            if (pendDue.size() > 0 && pendDue[0] <= cycle) begin
                base       = pendAddr[0][9:2];
                fill.valid = 1'b1;
                fill.addr  = pendAddr[0];
                fill.line  = {mem[{base[7:2], 2'd3}], mem[{base[7:2], 2'd2}],
                              mem[{base[7:2], 2'd1}], mem[{base[7:2], 2'd0}]};
                fillSeen   = 1'b1;
                pendAddr.delete(0);
                pendDue.delete(0);
            end

            // Stall bursts and redirects
            if (stallLeft == 0 && stallAt.size() > 0 && accepted >= stallAt[0]) begin
                stallLeft = stallLen[0];
                stallAt.delete(0);
                stallLen.delete(0);
            end
            stallNow = (stallLeft > 0);
            if (stallNow) begin
                stallLeft--;
            end
            decodeStall = stallNow;
            extRedirect = '0;
            redirNow    = 1'b0;
            if (!stallNow && redirAt.size() > 0 && accepted >= redirAt[0]) begin
                extRedirect.valid  = 1'b1;
                extRedirect.target = redirTgt[0];
                redirNow           = 1'b1;
                redirAt.delete(0);
                redirTgt.delete(0);
            end
            flushPrev = redirNow;

            // Reference model per accepted output
            if (fetchOut.valid && !stallNow) begin
                expFault = (expPc >= FetchPkg::MemBytes);
                expInsn  = expFault ? 32'h0 : mem[expPc[9:2]];
                compareValue("fetchOut.pc", expPc, fetchOut.pc);
                compareValue("fetchOut.insn", expInsn, fetchOut.insn);
                compareValue("fetchOut.trap.valid", 32'(expFault), 32'(fetchOut.trap.valid));
                compareValue("fetchOut.trap.cause",
                             expFault ? 32'(FetchPkg::CauseInsnAccessFault)
                                      : 32'(FetchPkg::CauseNone),
                             32'(fetchOut.trap.cause));
                compareValue("fetchOut.trap.value", expFault ? expPc : 32'h0,
                             fetchOut.trap.value);
                accepted++;
                if (!redirNow) begin
                    if (expFault) begin
                        expPc     = FetchPkg::TrapVector;
                        flushPrev = 1'b1;
                    end else begin
                        expPc = expPc + 32'd4;
                    end
                end
            end
            // Fetch restarts at the target even with no output this cycle
            if (redirNow) begin
                expPc = extRedirect.target;     // External wins over trap
            end
            stallPrev = stallNow;
            prevOut   = fetchOut;
        end

        if (accepted < expTotal) begin
            reportFailure($sformatf("Timeout after %0d cycles with %0d of %0d outputs accepted",
                                    cycle, accepted, expTotal));
        end
        closeTest();
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d of %0d outputs accepted",
                 testsRun, testsFailed, errors, accepted, expTotal);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/fetch_stimulus.txt ====
# M byte-address instruction (hex) | R after-count target (hex) | S after-count length
# T after-count test-number | E total accepted outputs | counts and lengths in decimal
M 000 00500093
M 004 00a00113
M 008 002081b3
M 00c 40208233
M 084 00000013
M 120 0000006f
M 124 00108093
M 200 34102573
M 204 30200073
T 1 2
T 26 3
S 28 3
S 33 5
T 40 4
R 42 120
R 55 084
T 62 5
R 64 400
R 72 7f0
E 80

// ==== hdl/FetchController.sv ====
// Redirect arbiter; external redirect beats a trap, traps only count when decode accepts
`timescale 1ns/1ps
`default_nettype none

module FetchController (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire FetchPkg::redirectT extRedirect,
    input  wire logic               decodeStall,
    input  wire FetchPkg::fetchOutT stageOut,
    output logic                    flush,
    output FetchPkg::redirectT      redirect,
    output logic                    ifStall
);

    typedef enum logic [1:0] {
        SrcNone,
        SrcExt,
        SrcTrap
    } redirSrcE;

    redirSrcE src;
    logic     trapSeen;     // Trap redirect issued last cycle
    logic     trapAccept;

    always_comb begin
        ifStall    = decodeStall;
        trapAccept = stageOut.valid && stageOut.trap.valid && !decodeStall && !trapSeen;

        // Source priority
        if (extRedirect.valid) begin
            src = SrcExt;
        end else if (trapAccept) begin
            src = SrcTrap;
        end else begin
            src = SrcNone;
        end

        redirect.valid  = (src != SrcNone);
        redirect.target = (src == SrcExt) ? extRedirect.target : FetchPkg::TrapVector;
        flush           = redirect.valid;     // Flush goes with every redirect
    end

    // ********************************************************
    // Trap suppression flag
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            trapSeen <= 1'b0;
        end else begin
            trapSeen <= (src == SrcTrap);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/FetchPkg.sv ====
// Shared fetch types; line geometry assumes LineWidth = LineInsns*InsnWidth, power-of-two sizes
`default_nettype none

package FetchPkg;

    // ********************************************************
    // Widths and geometry
    // ********************************************************
    localparam int XLen       = 32;
    localparam int InsnWidth  = 32;
    localparam int LineInsns  = 4;
    localparam int LineWidth  = LineInsns * InsnWidth;  // 128
    localparam int CacheLines = 8;

    localparam int InsnBytes   = InsnWidth / 8;
    localparam int WordLsb     = $clog2(InsnBytes);           // Byte offset bits in a word
    localparam int WordSelBits = $clog2(LineInsns);           // Word within line
    localparam int OffsetBits  = $clog2(LineWidth / 8);       // Byte offset within line
    localparam int IndexBits   = $clog2(CacheLines);
    localparam int TagBits     = XLen - OffsetBits - IndexBits;

    // Address map
    localparam logic [XLen-1:0] MemBytes   = 32'd1024;  // First non-fetchable address
    localparam logic [XLen-1:0] ResetPc    = 32'h0000_0000;
    localparam logic [XLen-1:0] TrapVector = 32'h0000_0200;  // Fixed, no CSR

    // RISC-V mcause numbering
    typedef enum logic [3:0] {
        CauseNone            = 4'd0,
        CauseInsnAccessFault = 4'd1
    } trapCauseE;

    typedef struct packed {
        logic            valid;
        trapCauseE       cause;
        logic [XLen-1:0] value;   // Faulting PC
    } trapInfoT;

    // Fetch unit to fetch stage
    typedef struct packed {
        logic                 valid;
        logic [XLen-1:0]      pc;
        logic                 fault;
        logic [LineWidth-1:0] line;
    } fetchReqT;

    // Fetch stage to decode
    typedef struct packed {
        logic                 valid;
        logic [XLen-1:0]      pc;
        logic [InsnWidth-1:0] insn;
        trapInfoT             trap;
    } fetchOutT;

    typedef struct packed {
        logic            valid;
        logic [XLen-1:0] target;
    } redirectT;

    // Line fill from outside memory
    typedef struct packed {
        logic                 valid;
        logic [XLen-1:0]      addr;   // Line aligned
        logic [LineWidth-1:0] line;
    } fillT;

endpackage

`default_nettype wire

// ==== hdl/FetchStage.sv ====
// Registers one instruction per cycle for decode; flush wins over stall
`timescale 1ns/1ps
`default_nettype none

module FetchStage (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire logic               flush,
    input  wire logic               ifStall,
    input  wire FetchPkg::fetchReqT req,
    output FetchPkg::fetchOutT      out
);

    logic [FetchPkg::WordSelBits-1:0]                         wordSel;
    logic [FetchPkg::LineInsns-1:0][FetchPkg::InsnWidth-1:0]  insns;
    logic [FetchPkg::InsnWidth-1:0]                           insn;

    // Word select within line
    always_comb begin
        wordSel = req.pc[FetchPkg::WordLsb +: FetchPkg::WordSelBits];
        insns   = req.line;
        insn    = insns[wordSel];
    end

    // ********************************************************
    // Output register
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            out <= '0;
        end else if (ifStall) begin
            out <= out;                                // Hold for decode
        end else if (req.fault) begin
            out.valid      <= req.valid;
            out.pc         <= req.pc;
            out.insn       <= '0;                      // No instruction on fault
            out.trap.valid <= 1'b1;
            out.trap.cause <= FetchPkg::CauseInsnAccessFault;
            out.trap.value <= req.pc;
        end else begin
            out.valid <= req.valid;                    // Low while missing
            out.pc    <= req.pc;
            out.insn  <= insn;
            out.trap  <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/FetchTop.sv ====
// Fetch front end top; miss/fill handshake has no back-pressure, decodeStall is a level
`timescale 1ns/1ps
`default_nettype none

module FetchTop (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire FetchPkg::redirectT extRedirect,
    input  wire logic               decodeStall,
    input  wire FetchPkg::fillT     fill,
    output logic                    missReq,
    output logic [FetchPkg::XLen-1:0] missAddr,
    output FetchPkg::fetchOutT      fetchOut
);

    // ********************************************************
    // Internal nets
    // ********************************************************
    logic [FetchPkg::XLen-1:0]      pc;
    logic                           hit;
    logic [FetchPkg::LineWidth-1:0] line;
    FetchPkg::fetchReqT             req;       // Unit to stage
    FetchPkg::redirectT             redirect;  // Controller to unit
    logic                           flush;
    logic                           ifStall;

    // Instruction cache
    InsnCache cache (
        .clk      (clk),
        .rstN     (rstN),
        .pc       (pc),
        .fill     (fill),
        .hit      (hit),
        .line     (line),
        .missReq  (missReq),
        .missAddr (missAddr)
    );

    // PC generator
    FetchUnit unit (
        .clk      (clk),
        .rstN     (rstN),
        .redirect (redirect),
        .ifStall  (ifStall),
        .hit      (hit),
        .line     (line),
        .pc       (pc),
        .req      (req)
    );

    // Output register toward decode
    FetchStage stage (
        .clk     (clk),
        .rstN    (rstN),
        .flush   (flush),
        .ifStall (ifStall),
        .req     (req),
        .out     (fetchOut)
    );

    FetchController ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .extRedirect (extRedirect),
        .decodeStall (decodeStall),
        .stageOut    (fetchOut),    // Trap seen at decode boundary
        .flush       (flush),
        .redirect    (redirect),
        .ifStall     (ifStall)
    );

endmodule

`default_nettype wire

// ==== hdl/FetchUnit.sv ====
// PC generator; a faulting PC (>= MemBytes) holds until redirected, misaligned PCs unchecked
`timescale 1ns/1ps
`default_nettype none

module FetchUnit (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire FetchPkg::redirectT            redirect,
    input  wire logic                          ifStall,
    input  wire logic                          hit,
    input  wire logic [FetchPkg::LineWidth-1:0] line,
    output logic [FetchPkg::XLen-1:0]          pc,
    output FetchPkg::fetchReqT                 req
);

    // ********************************************************
    // Fault detection and request
    // ********************************************************
    logic                      fault;
    logic                      advance;
    logic [FetchPkg::XLen-1:0] pcSeq;     // Next sequential PC
    logic [FetchPkg::XLen-1:0] pcNext;

    always_comb begin
        // Outside fetchable memory
        fault = (pc >= FetchPkg::MemBytes);

        // A fault is valid on its own, no line needed
        req.valid = hit || fault;
        req.pc    = pc;
        req.fault = fault;
        req.line  = line;
    end

    // ********************************************************
    // Next PC
    // ********************************************************
    always_comb begin
        pcSeq   = pc + FetchPkg::XLen'(FetchPkg::InsnBytes);
        advance = req.valid && !fault && !ifStall;   // Faulting PC stays put

        // Priority: redirect, stall, advance
        if (redirect.valid) begin
            pcNext = redirect.target;
        end else if (advance) begin
            pcNext = pcSeq;
        end else begin
            pcNext = pc;      // Stall or waiting on miss / redirect
        end
    end

    // PC register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= FetchPkg::ResetPc;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/InsnCache.sv ====
// Direct-mapped, no back-pressure on fills; no requests for PCs at or above MemBytes
`timescale 1ns/1ps
`default_nettype none

module InsnCache (
    input  wire logic                             clk,
    input  wire logic                             rstN,
    input  wire logic [FetchPkg::XLen-1:0]        pc,
    input  wire FetchPkg::fillT                   fill,
    output logic                                  hit,
    output logic [FetchPkg::LineWidth-1:0]        line,
    output logic                                  missReq,
    output logic [FetchPkg::XLen-1:0]             missAddr
);

    // ********************************************************
    // Storage
    // ********************************************************
    logic [FetchPkg::CacheLines-1:0] validBits;
    logic [FetchPkg::TagBits-1:0]    tags  [FetchPkg::CacheLines];
    logic [FetchPkg::LineWidth-1:0]  lines [FetchPkg::CacheLines];

    logic [FetchPkg::IndexBits-1:0] idx;       // Lookup index
    logic [FetchPkg::IndexBits-1:0] fillIdx;   // Write index
    logic [FetchPkg::TagBits-1:0]   tag;
    logic [FetchPkg::XLen-1:0]      lineAddr;  // Line-aligned PC
    logic                           pending;   // Miss outstanding at missAddr
    logic                           needReq;

    // Lookup
    always_comb begin
        idx      = pc[FetchPkg::OffsetBits +: FetchPkg::IndexBits];
        tag      = pc[FetchPkg::XLen-1 -: FetchPkg::TagBits];
        lineAddr = {pc[FetchPkg::XLen-1:FetchPkg::OffsetBits], {FetchPkg::OffsetBits{1'b0}}};
        fillIdx  = fill.addr[FetchPkg::OffsetBits +: FetchPkg::IndexBits];
        hit      = validBits[idx] && (tags[idx] == tag);
        line     = lines[idx];

        // New request only for a fetchable line not already asked for or arriving
        needReq = !hit && (pc < FetchPkg::MemBytes)
                  && !(pending && (missAddr == lineAddr))
                  && !(fill.valid && (fill.addr == lineAddr));
    end

    // ********************************************************
    // Control state
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
            pending   <= 1'b0;
            missReq   <= 1'b0;
        end else begin
            missReq <= needReq;                 // One-cycle strobe
            if (needReq) begin
                pending <= 1'b1;                // Also replaces an abandoned miss
            end else if (fill.valid && (fill.addr == missAddr)) begin
                pending <= 1'b0;
            end
            if (fill.valid) begin
                validBits[fillIdx] <= 1'b1;
            end
        end
    end

    // Payload, tags and line data
    always_ff @(posedge clk) begin
        if (needReq) begin
            missAddr <= lineAddr;
        end
        if (fill.valid) begin
            tags[fillIdx]  <= fill.addr[FetchPkg::XLen-1 -: FetchPkg::TagBits];
            lines[fillIdx] <= fill.line;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the fetch front end testbench, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module FetchTb -o fetchSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/fetchSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== src.f ====
hdl/FetchPkg.sv
hdl/InsnCache.sv
hdl/FetchUnit.sv
hdl/FetchStage.sv
hdl/FetchController.sv
hdl/FetchTop.sv
bench/FetchTb.sv
